/* cache_pkg.sv */
// Cache geometry, state codes, non-cacheable boundary and the address union
package cache_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int NUM_CACHES = 2;
    localparam int CACHE_ID_W = $clog2(NUM_CACHES);
    localparam int ICACHE_ID  = 0;
    localparam int DCACHE_ID  = 1;

    // One word per line, so only the byte offset sits below the index
    localparam int INDEX_W   = 4;
    localparam int NUM_LINES = 1 << INDEX_W;
    localparam int TAG_W     = ADDR_W - INDEX_W - 2;

    // Everything from here upward goes straight to memory
    localparam logic [ADDR_W-1:0] NONCACHE_START_ADDR = 32'h8000_0000;

    // Cache controller FSM encodings
    localparam int               STATE_W   = 3;
    localparam logic [STATE_W-1:0] ST_IDLE   = 3'd0;
    localparam logic [STATE_W-1:0] ST_WB     = 3'd1;
    localparam logic [STATE_W-1:0] ST_FILL   = 3'd2;
    localparam logic [STATE_W-1:0] ST_BYPASS = 3'd3;
    localparam logic [STATE_W-1:0] ST_FLUSH  = 3'd4;
    localparam logic [STATE_W-1:0] ST_CLEAR  = 3'd5;

    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
        logic [1:0]         offset;
    } cache_addr_fields_t;

    // A bus address seen either whole or split for the tag lookup
    typedef union packed {
        logic [ADDR_W-1:0]  raw;
        cache_addr_fields_t fields;
    } cache_addr_t;

endpackage

/* l1_cache.sv */
// Direct-mapped write-back L1 cache with Wishbone slave and master ports and flush/clear sweeps
`timescale 1ns/100ps

module l1_cache
    import cache_pkg::*;
(
    input  logic              CLK,
    input  logic              rst,
    input  logic              proc_cyc,
    input  logic              proc_stb,
    input  logic              proc_we,
    input  logic [ADDR_W-1:0] proc_adr,
    input  logic [DATA_W-1:0] proc_dat_w,
    output logic [DATA_W-1:0] proc_dat_r,
    output logic              proc_ack,
    output logic              mem_cyc,
    output logic              mem_stb,
    output logic              mem_we,
    output logic [ADDR_W-1:0] mem_adr,
    output logic [DATA_W-1:0] mem_dat_w,
    input  logic              mem_ack,
    input  logic [DATA_W-1:0] mem_dat_r,
    input  logic              flush_start,
    input  logic              clear_start,
    output logic              cache_miss,
    output logic              busy,
    output logic              sweep_done
);

    logic [STATE_W-1:0] state;
    logic [NUM_LINES-1:0] valid_q;
    logic [NUM_LINES-1:0] dirty_q;
    logic [TAG_W-1:0]     tag_q  [NUM_LINES];
    logic [DATA_W-1:0]    data_q [NUM_LINES];
    logic [INDEX_W-1:0]   sweep_idx;
    logic [INDEX_W-1:0]   line;
    cache_addr_t          lookup;
    cache_addr_t          req_addr;
    cache_addr_t          victim;
    logic                 req_we;
    logic [DATA_W-1:0]    req_data;
    logic                 proc_req;
    logic                 cacheable;
    logic                 hit;

    assign lookup.raw = proc_adr;
    assign cacheable  = proc_adr < NONCACHE_START_ADDR;
    assign hit        = valid_q[lookup.fields.index] &&
                        (tag_q[lookup.fields.index] == lookup.fields.tag);

    // The ack cycle still shows stb high, so it must not count as a new request
    assign proc_req = proc_cyc && proc_stb && !proc_ack;

    // The line under service is the sweep pointer during a flush, else the latched request
    assign line = (state == ST_FLUSH) ? sweep_idx : req_addr.fields.index;
    assign victim.fields = '{tag: tag_q[line], index: line, offset: 2'b00};

    assign busy = (state != ST_IDLE);

    always_ff @(posedge CLK) begin
        if (rst) begin
            state      <= ST_IDLE;
            valid_q    <= '0;
            dirty_q    <= '0;
            sweep_idx  <= '0;
            proc_ack   <= 1'b0;
            cache_miss <= 1'b0;
            sweep_done <= 1'b0;
            mem_cyc    <= 1'b0;
            mem_stb    <= 1'b0;
        end else begin
            proc_ack   <= 1'b0;
            cache_miss <= 1'b0;
            sweep_done <= 1'b0;
            if (mem_cyc && mem_ack) begin
                mem_cyc <= 1'b0;
                mem_stb <= 1'b0;
            end

            case (state)
                ST_IDLE: begin
                    if (flush_start) begin
                        sweep_idx <= '0;
                        state     <= ST_FLUSH;
                    end else if (clear_start) begin
                        // Line 0 goes now so the sweep takes exactly NUM_LINES cycles
                        valid_q[0] <= 1'b0;
                        dirty_q[0] <= 1'b0;
                        sweep_idx  <= INDEX_W'(1);
                        state      <= ST_CLEAR;
                    end else if (proc_req) begin
                        req_addr.raw <= proc_adr;
                        req_we       <= proc_we;
                        req_data     <= proc_dat_w;
                        if (!cacheable) begin
                            state <= ST_BYPASS;
                        end else if (hit) begin
                            proc_ack   <= 1'b1;
                            proc_dat_r <= data_q[lookup.fields.index];
                            if (proc_we) begin
                                data_q[lookup.fields.index]  <= proc_dat_w;
                                dirty_q[lookup.fields.index] <= 1'b1;
                            end
                        end else begin
                            cache_miss <= 1'b1;
                            state      <= ST_WB;
                        end
                    end
                end

                // Both states write back a dirty line first, then go on once it is clean
                ST_WB, ST_FLUSH: begin
                    if (mem_cyc) begin
                        if (mem_ack) begin
                            dirty_q[line] <= 1'b0;
                        end
                    end else if (valid_q[line] && dirty_q[line]) begin
                        mem_cyc   <= 1'b1;
                        mem_stb   <= 1'b1;
                        mem_we    <= 1'b1;
                        mem_adr   <= victim.raw;
                        mem_dat_w <= data_q[line];
                    end else if (state == ST_FLUSH) begin
                        valid_q[line] <= 1'b0;
                        sweep_idx     <= sweep_idx + 1'b1;
                        if (sweep_idx == INDEX_W'(NUM_LINES - 1)) begin
                            sweep_done <= 1'b1;
                            state      <= ST_IDLE;
                        end
                    end else if (req_we) begin
                        // A write miss allocates without a fill since the line is one word
                        data_q[line]  <= req_data;
                        tag_q[line]   <= req_addr.fields.tag;
                        valid_q[line] <= 1'b1;
                        dirty_q[line] <= 1'b1;
                        proc_ack      <= 1'b1;
                        state         <= ST_IDLE;
                    end else begin
                        state <= ST_FILL;
                    end
                end

                // A fill is always a read, so req_we is the right bus direction for both
                ST_FILL, ST_BYPASS: begin
                    if (!mem_cyc) begin
                        mem_cyc   <= 1'b1;
                        mem_stb   <= 1'b1;
                        mem_we    <= req_we;
                        mem_adr   <= req_addr.raw;
                        mem_dat_w <= req_data;
                    end else if (mem_ack) begin
                        proc_dat_r <= mem_dat_r;
                        proc_ack   <= 1'b1;
                        state      <= ST_IDLE;
                        if (state == ST_FILL) begin
                            data_q[line]  <= mem_dat_r;
                            tag_q[line]   <= req_addr.fields.tag;
                            valid_q[line] <= 1'b1;
                            dirty_q[line] <= 1'b0;
                        end
                    end
                end

                ST_CLEAR: begin
                    valid_q[sweep_idx] <= 1'b0;
                    dirty_q[sweep_idx] <= 1'b0;
                    sweep_idx          <= sweep_idx + 1'b1;
                    if (sweep_idx == INDEX_W'(NUM_LINES - 1)) begin
                        sweep_done <= 1'b1;
                        state      <= ST_IDLE;
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

    // The ack only answers a cycle the processor still holds open
    assert property (@(posedge CLK) disable iff (rst)
        proc_ack |-> (proc_cyc && proc_stb));

    assert property (@(posedge CLK) disable iff (rst)
        proc_ack |=> !proc_ack);

endmodule

/* cache_maint_ctrl.sv */
// Flush and clear request sequencer that starts sweeps on idle caches and reports completion
`timescale 1ns/100ps

module cache_maint_ctrl
    import cache_pkg::*;
(
    input  logic                  CLK,
    input  logic                  rst,
    input  logic [NUM_CACHES-1:0] flush_req,
    input  logic [NUM_CACHES-1:0] clear_req,
    input  logic [NUM_CACHES-1:0] busy,
    input  logic [NUM_CACHES-1:0] sweep_done,
    output logic [NUM_CACHES-1:0] flush_start,
    output logic [NUM_CACHES-1:0] clear_start,
    output logic [NUM_CACHES-1:0] flush_done,
    output logic [NUM_CACHES-1:0] clear_done
);

    logic [NUM_CACHES-1:0] flush_pend;
    logic [NUM_CACHES-1:0] clear_pend;
    logic [NUM_CACHES-1:0] run_flush;
    logic [NUM_CACHES-1:0] run_clear;
    logic [NUM_CACHES-1:0] ready;

    // Starts are combinational so the cache sees them in the same idle cycle
    // that was checked, before it can accept a processor access
    assign ready       = ~busy & ~run_flush & ~run_clear;
    assign flush_start = flush_pend & ready;
    assign clear_start = clear_pend & ~flush_pend & ready;

    always_ff @(posedge CLK) begin
        if (rst) begin
            flush_pend <= '0;
            clear_pend <= '0;
            run_flush  <= '0;
            run_clear  <= '0;
            flush_done <= '0;
            clear_done <= '0;
        end else begin
            flush_pend <= (flush_pend & ~flush_start) | flush_req;
            clear_pend <= (clear_pend & ~clear_start) | clear_req;
            run_flush  <= (run_flush & ~sweep_done) | flush_start;
            run_clear  <= (run_clear & ~sweep_done) | clear_start;
            flush_done <= run_flush & sweep_done;
            clear_done <= run_clear & sweep_done;
        end
    end

    assert property (@(posedge CLK) disable iff (rst)
        (flush_done & clear_done) == '0);

    // A cache only finishes a sweep that was started from here
    assert property (@(posedge CLK) disable iff (rst)
        (sweep_done & ~(run_flush | run_clear)) == '0);

endmodule

/* mem_arbiter.sv */
// Round-robin arbiter merging the cache master ports onto one Wishbone classic master
`timescale 1ns/100ps

module mem_arbiter
    import cache_pkg::*;
(
    input  logic                              CLK,
    input  logic                              rst,
    input  logic [NUM_CACHES-1:0]             c_cyc,
    input  logic [NUM_CACHES-1:0]             c_stb,
    input  logic [NUM_CACHES-1:0]             c_we,
    input  logic [NUM_CACHES-1:0][ADDR_W-1:0] c_adr,
    input  logic [NUM_CACHES-1:0][DATA_W-1:0] c_dat_w,
    output logic [NUM_CACHES-1:0]             c_ack,
    output logic [NUM_CACHES-1:0][DATA_W-1:0] c_dat_r,
    output logic                              mem_cyc,
    output logic                              mem_stb,
    output logic                              mem_we,
    output logic [ADDR_W-1:0]                 mem_adr,
    output logic [DATA_W-1:0]                 mem_dat_w,
    input  logic                              mem_ack,
    input  logic [DATA_W-1:0]                 mem_dat_r
);

    logic                  gnt_valid;
    logic [CACHE_ID_W-1:0] gnt_idx;
    logic [CACHE_ID_W-1:0] rr_ptr;
    logic [CACHE_ID_W-1:0] pick_idx;
    int unsigned           cand;

    // Scan from the pointer outward; the nearest requester wins
    always_comb begin
        pick_idx = rr_ptr;
        cand     = 0;
        for (int k = NUM_CACHES - 1; k >= 0; k--) begin
            cand = (rr_ptr + k) % NUM_CACHES;
            if (c_cyc[cand]) begin
                pick_idx = CACHE_ID_W'(cand);
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            gnt_valid <= 1'b0;
            gnt_idx   <= '0;
            rr_ptr    <= '0;
        end else if (!gnt_valid) begin
            if (|c_cyc) begin
                gnt_valid <= 1'b1;
                gnt_idx   <= pick_idx;
            end
        end else if (!c_cyc[gnt_idx]) begin
            gnt_valid <= 1'b0;
            rr_ptr    <= (gnt_idx == CACHE_ID_W'(NUM_CACHES - 1)) ? '0 : gnt_idx + 1'b1;
        end
    end

    assign mem_cyc   = gnt_valid && c_cyc[gnt_idx];
    assign mem_stb   = gnt_valid && c_stb[gnt_idx];
    assign mem_we    = c_we[gnt_idx];
    assign mem_adr   = c_adr[gnt_idx];
    assign mem_dat_w = c_dat_w[gnt_idx];

    always_comb begin
        c_ack            = '0;
        c_dat_r          = '0;
        c_ack[gnt_idx]   = mem_cyc && mem_ack;
        c_dat_r[gnt_idx] = mem_dat_r;
    end

    assert property (@(posedge CLK) disable iff (rst)
        $onehot0(c_ack));

    // A cache holds its request steady until memory answers it
    assert property (@(posedge CLK) disable iff (rst)
        (mem_stb && !mem_ack) |=> (mem_stb && $stable(mem_adr) && $stable(mem_we)));

endmodule

/* separate_caches.sv */
// Split instruction and data L1 caches sharing one memory port, with flush/clear control
`timescale 1ns/100ps

module separate_caches
    import cache_pkg::*;
(
    input  logic                              CLK,
    input  logic                              rst,
    input  logic [NUM_CACHES-1:0]             proc_cyc,
    input  logic [NUM_CACHES-1:0]             proc_stb,
    input  logic [NUM_CACHES-1:0]             proc_we,
    input  logic [NUM_CACHES-1:0][ADDR_W-1:0] proc_adr,
    input  logic [NUM_CACHES-1:0][DATA_W-1:0] proc_dat_w,
    output logic [NUM_CACHES-1:0][DATA_W-1:0] proc_dat_r,
    output logic [NUM_CACHES-1:0]             proc_ack,
    input  logic [NUM_CACHES-1:0]             flush_req,
    input  logic [NUM_CACHES-1:0]             clear_req,
    output logic [NUM_CACHES-1:0]             flush_done,
    output logic [NUM_CACHES-1:0]             clear_done,
    output logic [NUM_CACHES-1:0]             cache_miss,
    output logic                              mem_cyc,
    output logic                              mem_stb,
    output logic                              mem_we,
    output logic [ADDR_W-1:0]                 mem_adr,
    output logic [DATA_W-1:0]                 mem_dat_w,
    input  logic                              mem_ack,
    input  logic [DATA_W-1:0]                 mem_dat_r
);

    logic [NUM_CACHES-1:0]             c_cyc;
    logic [NUM_CACHES-1:0]             c_stb;
    logic [NUM_CACHES-1:0]             c_we;
    logic [NUM_CACHES-1:0][ADDR_W-1:0] c_adr;
    logic [NUM_CACHES-1:0][DATA_W-1:0] c_dat_w;
    logic [NUM_CACHES-1:0]             c_ack;
    logic [NUM_CACHES-1:0][DATA_W-1:0] c_dat_r;
    logic [NUM_CACHES-1:0]             busy;
    logic [NUM_CACHES-1:0]             sweep_done;
    logic [NUM_CACHES-1:0]             flush_start;
    logic [NUM_CACHES-1:0]             clear_start;

    cache_maint_ctrl maint_inst (
        .CLK         (CLK),
        .rst         (rst),
        .flush_req   (flush_req),
        .clear_req   (clear_req),
        .busy        (busy),
        .sweep_done  (sweep_done),
        .flush_start (flush_start),
        .clear_start (clear_start),
        .flush_done  (flush_done),
        .clear_done  (clear_done)
    );

    // Entry 0 is the instruction cache and entry 1 the data cache
    for (genvar i = 0; i < NUM_CACHES; i++) begin : g_cache
        l1_cache cache_inst (
            .CLK         (CLK),
            .rst         (rst),
            .proc_cyc    (proc_cyc[i]),
            .proc_stb    (proc_stb[i]),
            .proc_we     (proc_we[i]),
            .proc_adr    (proc_adr[i]),
            .proc_dat_w  (proc_dat_w[i]),
            .proc_dat_r  (proc_dat_r[i]),
            .proc_ack    (proc_ack[i]),
            .mem_cyc     (c_cyc[i]),
            .mem_stb     (c_stb[i]),
            .mem_we      (c_we[i]),
            .mem_adr     (c_adr[i]),
            .mem_dat_w   (c_dat_w[i]),
            .mem_ack     (c_ack[i]),
            .mem_dat_r   (c_dat_r[i]),
            .flush_start (flush_start[i]),
            .clear_start (clear_start[i]),
            .cache_miss  (cache_miss[i]),
            .busy        (busy[i]),
            .sweep_done  (sweep_done[i])
        );
    end

    mem_arbiter arb_inst (
        .CLK       (CLK),
        .rst       (rst),
        .c_cyc     (c_cyc),
        .c_stb     (c_stb),
        .c_we      (c_we),
        .c_adr     (c_adr),
        .c_dat_w   (c_dat_w),
        .c_ack     (c_ack),
        .c_dat_r   (c_dat_r),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_we    (mem_we),
        .mem_adr   (mem_adr),
        .mem_dat_w (mem_dat_w),
        .mem_ack   (mem_ack),
        .mem_dat_r (mem_dat_r)
    );

endmodule

/* tb_separate_caches.sv */
// Testbench for separate_caches with LFSR stimulus, memory model, reference model and checks
`timescale 1ns/100ps

module tb_separate_caches
    import cache_pkg::*;
;

    localparam int N_TRANS = 470;
    localparam int N_MAINT = 4;
    localparam int CYCLE_LIMIT = 200 * N_TRANS + 400 * N_MAINT;

    logic                              CLK;
    logic                              rst;
    logic [NUM_CACHES-1:0]             proc_cyc, proc_stb, proc_we, proc_ack;
    logic [NUM_CACHES-1:0][ADDR_W-1:0] proc_adr;
    logic [NUM_CACHES-1:0][DATA_W-1:0] proc_dat_w, proc_dat_r;
    logic [NUM_CACHES-1:0]             flush_req, clear_req, flush_done, clear_done;
    logic [NUM_CACHES-1:0]             cache_miss;
    logic                              mem_cyc, mem_stb, mem_we, mem_ack;
    logic [ADDR_W-1:0]                 mem_adr;
    logic [DATA_W-1:0]                 mem_dat_w, mem_dat_r;

    logic [31:0]       lfsr;
    int                cycles;
    logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
    logic [DATA_W-1:0] bk  [logic [ADDR_W-1:0]];
    logic              mv  [NUM_CACHES][NUM_LINES];
    logic              md  [NUM_CACHES][NUM_LINES];
    logic [TAG_W-1:0]  mt  [NUM_CACHES][NUM_LINES];
    logic [DATA_W-1:0] ml  [NUM_CACHES][NUM_LINES];
    logic [ADDR_W-1:0] written [$];
    int                wait_left;
    logic              mem_busy;

    separate_caches separate_caches_inst (.*);

    always #10 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Run stopped because the cycle limit was reached");
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

    // Galois LFSR stepped once for every bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0001) : (lfsr >> 1);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Untouched memory reads back a pattern built from the whole address
    function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
        return {a[15:0], a[31:16]} ^ 32'hc3a5_0f1e ^ (a * 32'h9e37_79b9);
    endfunction

    function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] a);
        return mem.exists(a) ? mem[a] : fill_word(a);
    endfunction

    function automatic logic [DATA_W-1:0] bk_word(input logic [ADDR_W-1:0] a);
        return bk.exists(a) ? bk[a] : fill_word(a);
    endfunction

    task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_miss(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_mem(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t mem[%h] got %h expected %h", $time, a, got, exp);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    // Memory slave with 0 to 3 wait states per cycle
    always @(negedge CLK) begin
        if (rst) begin
            mem_ack  = 1'b0;
            mem_busy = 1'b0;
        end else if (mem_ack) begin
            mem_ack  = 1'b0;
            mem_busy = 1'b0;
        end else if (mem_cyc && mem_stb) begin
            if (!mem_busy) begin
                mem_busy  = 1'b1;
                wait_left = int'(rand_bits(2));
            end
            if (wait_left == 0) begin
                mem_ack = 1'b1;
                if (mem_we) begin
                    mem[mem_adr] = mem_dat_w;
                end else begin
                    mem_dat_r = mem_word(mem_adr);
                end
            end else begin
                wait_left--;
            end
        end
    end

    task automatic access(input int id, input logic we, input logic [ADDR_W-1:0] a,
                          input logic [DATA_W-1:0] d);
        cache_addr_t       ca;
        cache_addr_t       vic;
        logic              cacheable;
        logic              hit;
        logic              missed;
        logic [DATA_W-1:0] exp;
        ca.raw    = a;
        cacheable = a < NONCACHE_START_ADDR;
        hit       = mv[id][ca.fields.index] && (mt[id][ca.fields.index] == ca.fields.tag);
        exp       = (cacheable && hit) ? ml[id][ca.fields.index] : bk_word(a);
        missed    = 1'b0;
        proc_cyc[id]   = 1'b1;
        proc_stb[id]   = 1'b1;
        proc_we[id]    = we;
        proc_adr[id]   = a;
        proc_dat_w[id] = d;
        do begin
            @(negedge CLK);
            missed = missed | cache_miss[id];
        end while (!proc_ack[id]);
        if (!we) begin
            check_data($sformatf("proc_dat_r[%0d] @%h", id, a), proc_dat_r[id], exp);
        end
        check_miss($sformatf("cache_miss[%0d] @%h", id, a), missed, cacheable && !hit);
        if (!cacheable) begin
            if (we) begin
                bk[a] = d;
                check_mem(a, mem_word(a), d);
            end
        end else begin
            if (!hit && mv[id][ca.fields.index] && md[id][ca.fields.index]) begin
                vic.fields = '{tag: mt[id][ca.fields.index], index: ca.fields.index,
                               offset: 2'b00};
                bk[vic.raw] = ml[id][ca.fields.index];
            end
            if (!hit) begin
                ml[id][ca.fields.index] = bk_word(a);
                md[id][ca.fields.index] = 1'b0;
            end
            mv[id][ca.fields.index] = 1'b1;
            mt[id][ca.fields.index] = ca.fields.tag;
            if (we) begin
                ml[id][ca.fields.index] = d;
                md[id][ca.fields.index] = 1'b1;
                written.push_back(a);
            end
        end
        // The request stays up until the edge that samples the ack
        @(negedge CLK);
        proc_cyc[id] = 1'b0;
        proc_stb[id] = 1'b0;
    endtask

    // Data cache mixes conflicting cacheable lines with a small uncached window
    task automatic random_data_access();
        logic [ADDR_W-1:0] a;
        logic              we;
        if (rand_bits(2) == 0) begin
            a = NONCACHE_START_ADDR + (rand_bits(4) << 2);
        end else begin
            a = 32'h0000_1000 + (rand_bits(3) << 6) + (rand_bits(4) << 2);
        end
        we = (rand_bits(1) != 32'd0);
        access(DCACHE_ID, we, a, rand_bits(32));
    endtask

    // Instruction fetches stay in a region the data cache never writes
    task automatic random_fetch();
        access(ICACHE_ID, 1'b0, 32'h0002_0000 + (rand_bits(3) << 6) + (rand_bits(4) << 2), '0);
    endtask

    task automatic maintain(input int id, input logic is_flush);
        cache_addr_t vic;
        int          dones;
        int          wrong;
        dones = 0;
        wrong = 0;
        if (is_flush) begin
            flush_req[id] = 1'b1;
        end else begin
            clear_req[id] = 1'b1;
        end
        @(negedge CLK);
        flush_req[id] = 1'b0;
        clear_req[id] = 1'b0;
        while (dones == 0) begin
            @(negedge CLK);
            dones = dones + (is_flush ? flush_done[id] : clear_done[id]);
            wrong = wrong + (is_flush ? clear_done[id] : flush_done[id]);
        end
        repeat (3) begin
            @(negedge CLK);
            dones = dones + flush_done[id] + clear_done[id];
        end
        if (dones != 1 || wrong != 0) begin
            $display("Cache %0d gave the wrong number or kind of done pulses", id);
            $display("TESTS FAILED");
            $fatal(1);
        end
        for (int i = 0; i < NUM_LINES; i++) begin
            if (is_flush && mv[id][i] && md[id][i]) begin
                vic.fields = '{tag: mt[id][i], index: INDEX_W'(i), offset: 2'b00};
                bk[vic.raw] = ml[id][i];
            end
            mv[id][i] = 1'b0;
            md[id][i] = 1'b0;
        end
        if (is_flush) begin
            foreach (written[k]) begin
                check_mem(written[k], mem_word(written[k]), bk_word(written[k]));
            end
        end
    endtask

    initial begin
        CLK        = 1'b0;
        rst        = 1'b1;
        lfsr       = 32'hfa7f_c9f6;
        cycles     = 0;
        proc_cyc   = '0;
        proc_stb   = '0;
        proc_we    = '0;
        proc_adr   = '0;
        proc_dat_w = '0;
        flush_req  = '0;
        clear_req  = '0;
        mem_ack    = 1'b0;
        mem_dat_r  = '0;
        mem_busy   = 1'b0;
        wait_left  = 0;
        for (int c = 0; c < NUM_CACHES; c++) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                mv[c][i] = 1'b0;
                md[c][i] = 1'b0;
                mt[c][i] = '0;
                ml[c][i] = '0;
            end
        end
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        rst = 1'b0;

        repeat (150) random_data_access();
        maintain(DCACHE_ID, 1'b1);
        repeat (40) random_data_access();
        maintain(DCACHE_ID, 1'b0);
        repeat (40) random_data_access();

        // Both caches run together and each is flushed in the middle of its own stream
        fork
            begin
                repeat (60) random_fetch();
                maintain(ICACHE_ID, 1'b1);
                repeat (60) random_fetch();
            end
            begin
                repeat (60) random_data_access();
                maintain(DCACHE_ID, 1'b1);
                repeat (60) random_data_access();
            end
        join

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* compile.f */
cache_pkg.sv
l1_cache.sv
cache_maint_ctrl.sv
mem_arbiter.sv
separate_caches.sv
tb_separate_caches.sv

/* Bender.yml */
package:
  name: separate_caches

sources:
  - cache_pkg.sv
  - l1_cache.sv
  - cache_maint_ctrl.sv
  - mem_arbiter.sv
  - separate_caches.sv
  - target: simulation
    files:
      - tb_separate_caches.sv
